// ==== csr_apb.sv ====
/*
  APB slave for the host CSRs: 0x0 loader flits, 0x4 host-to-processor words,
  0x8 processor-to-host fill count, 0xC processor-to-host pop.
*/
`timescale 1ns/1ps
`default_nettype none

module csr_apb #(
  parameter int MMIO_ELS = 16
) (
  input  wire                                   clk,
  input  wire                                   reset,
  input  wire                                   psel_i,
  input  wire                                   penable_i,
  input  wire                                   pwrite_i,
  input  wire [fpga_host_pkg::CSR_ADDR_W-1:0]   paddr_i,
  input  wire fpga_host_pkg::word_t             pwdata_i,
  output fpga_host_pkg::word_t                  prdata_o,
  output logic                                  pready_o,
  output logic                                  pslverr_o,
  output logic                                  flit_valid_o,
  output fpga_host_pkg::word_t                  flit_data_o,
  input  wire                                   flit_ready_i,
  output logic                                  h2b_valid_o,
  output fpga_host_pkg::word_t                  h2b_data_o,
  input  wire                                   h2b_ready_i,
  input  wire                                   b2h_valid_i,
  input  wire fpga_host_pkg::word_t             b2h_data_i,
  output logic                                  b2h_yumi_o,
  input  wire [$clog2(MMIO_ELS+1)-1:0]          b2h_count_i
);

  import fpga_host_pkg::*;

  logic  setup;
  logic  access;
  logic  hit_nbf;
  logic  hit_h2b;
  logic  hit_cnt;
  logic  hit_b2h;
  logic  mapped;
  logic  err_d;
  word_t rdata_d;

  assign setup  = psel_i & ~penable_i;
  assign access = psel_i & penable_i;

  assign hit_nbf = (paddr_i == CSR_NBF);
  assign hit_h2b = (paddr_i == CSR_HOST_TO_BP);
  assign hit_cnt = (paddr_i == CSR_BP_TO_HOST_CNT);
  assign hit_b2h = (paddr_i == CSR_BP_TO_HOST);
  assign mapped  = hit_nbf | hit_h2b | hit_cnt | hit_b2h;

  // write side, data goes straight through in the access phase
  assign flit_valid_o = access & pwrite_i & hit_nbf;
  assign flit_data_o  = pwdata_i;
  assign h2b_valid_o  = access & pwrite_i & hit_h2b;
  assign h2b_data_o   = pwdata_i;

  // only writes to a push target can stall
  always_comb begin
    pready_o = 1'b1;
    if (pwrite_i && hit_nbf) begin
      pready_o = flit_ready_i;
    end else if (pwrite_i && hit_h2b) begin
      pready_o = h2b_ready_i;
    end
  end

  // read-only CSRs reject writes
  assign err_d = ~mapped | (pwrite_i & (hit_cnt | hit_b2h));

  // pop in the setup phase so the head word is registered for the access phase
  assign b2h_yumi_o = setup & ~pwrite_i & hit_b2h & b2h_valid_i;

  always_comb begin
    rdata_d = '0;
    if (!pwrite_i && hit_cnt) begin
      rdata_d = CSR_DATA_W'(b2h_count_i);
    end else if (!pwrite_i && hit_b2h && b2h_valid_i) begin
      rdata_d = b2h_data_i;
    end
  end

  // error flag lives only for the access it belongs to
  always_ff @(posedge clk) begin
    if (reset) begin
      pslverr_o <= 1'b0;
    end else if (setup) begin
      pslverr_o <= err_d;
    end else if (access && pready_o) begin
      pslverr_o <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (setup) begin
      prdata_o <= rdata_d;
    end
  end

endmodule

`default_nettype wire

// ==== fpga_host.f ====
fpga_host_pkg.sv
word_fifo.sv
csr_apb.sv
nbf_deserializer.sv
nbf_issue.sv
fpga_host.sv
tb_fpga_host.sv

// ==== fpga_host.sv ====
/*
  Top level of the FPGA host bridge: APB CSR decode, flit deserializer, packet queue,
  write issue, and the two word buffers between host and processor.
*/
`timescale 1ns/1ps
`default_nettype none

module fpga_host #(
  parameter int MMIO_ELS       = 16,
  parameter int NBF_MAX_WRITES = 4
) (
  input  wire                                   clk,
  input  wire                                   reset,
  // host APB
  input  wire                                   psel_i,
  input  wire                                   penable_i,
  input  wire                                   pwrite_i,
  input  wire [fpga_host_pkg::CSR_ADDR_W-1:0]   paddr_i,
  input  wire fpga_host_pkg::word_t             pwdata_i,
  output fpga_host_pkg::word_t                  prdata_o,
  output logic                                  pready_o,
  output logic                                  pslverr_o,
  // outbound writes
  output logic                                  wr_valid_o,
  input  wire                                   wr_ready_i,
  output logic [fpga_host_pkg::NBF_ADDR_W-1:0]  wr_addr_o,
  output logic [fpga_host_pkg::NBF_DATA_W-1:0]  wr_data_o,
  output logic [1:0]                            wr_size_o,
  input  wire                                   wr_done_i,
  // processor word streams
  output logic                                  bp_in_valid_o,
  input  wire                                   bp_in_ready_i,
  output fpga_host_pkg::word_t                  bp_in_data_o,
  input  wire                                   bp_out_valid_i,
  output logic                                  bp_out_ready_o,
  input  wire fpga_host_pkg::word_t             bp_out_data_i
);

  import fpga_host_pkg::*;

  localparam int CNT_W = $clog2(MMIO_ELS + 1);

  logic             flit_valid;
  word_t            flit_data;
  logic             flit_ready;
  logic             h2b_valid;
  word_t            h2b_data;
  logic             h2b_ready;
  logic             b2h_valid;
  word_t            b2h_data;
  logic             b2h_yumi;
  logic [CNT_W-1:0] b2h_count;
  logic             dsr_valid;
  nbf_pkt_t         dsr_pkt;
  logic             dsr_ready;
  logic             q_valid;
  nbf_pkt_t         q_pkt;
  logic             q_yumi;

  csr_apb #(
    .MMIO_ELS(MMIO_ELS)
  ) u_csr_apb (
    .clk          (clk),
    .reset        (reset),
    .psel_i       (psel_i),
    .penable_i    (penable_i),
    .pwrite_i     (pwrite_i),
    .paddr_i      (paddr_i),
    .pwdata_i     (pwdata_i),
    .prdata_o     (prdata_o),
    .pready_o     (pready_o),
    .pslverr_o    (pslverr_o),
    .flit_valid_o (flit_valid),
    .flit_data_o  (flit_data),
    .flit_ready_i (flit_ready),
    .h2b_valid_o  (h2b_valid),
    .h2b_data_o   (h2b_data),
    .h2b_ready_i  (h2b_ready),
    .b2h_valid_i  (b2h_valid),
    .b2h_data_i   (b2h_data),
    .b2h_yumi_o   (b2h_yumi),
    .b2h_count_i  (b2h_count)
  );

  nbf_deserializer u_nbf_deserializer (
    .clk          (clk),
    .reset        (reset),
    .flit_valid_i (flit_valid),
    .flit_data_i  (flit_data),
    .flit_ready_o (flit_ready),
    .pkt_valid_o  (dsr_valid),
    .pkt_o        (dsr_pkt),
    .pkt_ready_i  (dsr_ready)
  );

  word_fifo #(
    .MMIO_ELS  (MMIO_ELS),
    .payload_t (nbf_pkt_t)
  ) pkt_queue (
    .clk          (clk),
    .reset        (reset),
    .push_valid_i (dsr_valid),
    .push_data_i  (dsr_pkt),
    .push_ready_o (dsr_ready),
    .pop_valid_o  (q_valid),
    .pop_data_o   (q_pkt),
    .pop_yumi_i   (q_yumi),
    .count_o      ()
  );

  nbf_issue #(
    .NBF_MAX_WRITES(NBF_MAX_WRITES)
  ) u_nbf_issue (
    .clk         (clk),
    .reset       (reset),
    .pkt_valid_i (q_valid),
    .pkt_i       (q_pkt),
    .pkt_yumi_o  (q_yumi),
    .wr_valid_o  (wr_valid_o),
    .wr_ready_i  (wr_ready_i),
    .wr_addr_o   (wr_addr_o),
    .wr_data_o   (wr_data_o),
    .wr_size_o   (wr_size_o),
    .wr_done_i   (wr_done_i)
  );

  // the FIFO ignores yumi while empty, so ready serves as yumi
  word_fifo #(
    .MMIO_ELS  (MMIO_ELS),
    .payload_t (word_t)
  ) h2b_buffer (
    .clk          (clk),
    .reset        (reset),
    .push_valid_i (h2b_valid),
    .push_data_i  (h2b_data),
    .push_ready_o (h2b_ready),
    .pop_valid_o  (bp_in_valid_o),
    .pop_data_o   (bp_in_data_o),
    .pop_yumi_i   (bp_in_ready_i),
    .count_o      ()
  );

  word_fifo #(
    .MMIO_ELS  (MMIO_ELS),
    .payload_t (word_t)
  ) b2h_buffer (
    .clk          (clk),
    .reset        (reset),
    .push_valid_i (bp_out_valid_i),
    .push_data_i  (bp_out_data_i),
    .push_ready_o (bp_out_ready_o),
    .pop_valid_o  (b2h_valid),
    .pop_data_o   (b2h_data),
    .pop_yumi_i   (b2h_yumi),
    .count_o      (b2h_count)
  );

endmodule

`default_nettype wire

// ==== fpga_host_pkg.sv ====
/*
  Shared widths, host CSR map, loader opcodes and packet layout for the FPGA host bridge.
  Modules import it inside their body and use scoped names in their port lists.
*/
`default_nettype none

package fpga_host_pkg;

  localparam int CSR_DATA_W = 32;
  localparam int CSR_ADDR_W = 4;

  localparam int NBF_ADDR_W   = 64;
  localparam int NBF_DATA_W   = 64;
  localparam int NBF_OPCODE_W = 8;
  localparam int NBF_FLITS    = 5;

  // host CSR map
  localparam logic [CSR_ADDR_W-1:0] CSR_NBF            = 4'h0;
  localparam logic [CSR_ADDR_W-1:0] CSR_HOST_TO_BP     = 4'h4;
  localparam logic [CSR_ADDR_W-1:0] CSR_BP_TO_HOST_CNT = 4'h8;
  localparam logic [CSR_ADDR_W-1:0] CSR_BP_TO_HOST     = 4'hC;

  // loader opcodes
  localparam logic [NBF_OPCODE_W-1:0] OP_WRITE32 = 8'h02;
  localparam logic [NBF_OPCODE_W-1:0] OP_WRITE64 = 8'h03;
  localparam logic [NBF_OPCODE_W-1:0] OP_FENCE   = 8'hFE;
  localparam logic [NBF_OPCODE_W-1:0] OP_FINISH  = 8'hFF;

  // wr_size encodings, log2 of the byte count
  localparam logic [1:0] SIZE_32 = 2'd2;
  localparam logic [1:0] SIZE_64 = 2'd3;

  typedef logic [CSR_DATA_W-1:0] word_t;

  // data in the low bits, then addr, opcode on top
  typedef struct packed {
    logic [NBF_OPCODE_W-1:0] opcode;
    logic [NBF_ADDR_W-1:0]   addr;
    logic [NBF_DATA_W-1:0]   data;
  } nbf_pkt_t;

endpackage

`default_nettype wire

// ==== nbf_deserializer.sv ====
/*
  Collects five 32-bit loader flits into one packet.
  The packet is held, with flits refused, until the packet queue takes it.
*/
`timescale 1ns/1ps
`default_nettype none

module nbf_deserializer (
  input  wire                      clk,
  input  wire                      reset,
  input  wire                      flit_valid_i,
  input  wire fpga_host_pkg::word_t flit_data_i,
  output logic                     flit_ready_o,
  output logic                     pkt_valid_o,
  output fpga_host_pkg::nbf_pkt_t  pkt_o,
  input  wire                      pkt_ready_i
);

  import fpga_host_pkg::*;

  localparam int CNT_W = $clog2(NBF_FLITS + 1);

  logic [CNT_W-1:0]            cnt_q;
  word_t [NBF_FLITS-1:0]       flit_q;
  logic                        flit_fire;
  logic                        pkt_fire;

  assign flit_ready_o = (cnt_q != CNT_W'(NBF_FLITS));
  assign pkt_valid_o  = (cnt_q == CNT_W'(NBF_FLITS));

  assign flit_fire = flit_valid_i & flit_ready_o;
  assign pkt_fire  = pkt_valid_o & pkt_ready_i;

  // new flits enter at the top, so flit 0 settles in slot 0
  always_ff @(posedge clk) begin
    if (flit_fire) begin
      flit_q <= {flit_data_i, flit_q[NBF_FLITS-1:1]};
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      cnt_q <= '0;
    end else if (pkt_fire) begin
      cnt_q <= '0;
    end else if (flit_fire) begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  // upper bits of the opcode flit are dropped
  assign pkt_o = nbf_pkt_t'({flit_q[NBF_FLITS-1][NBF_OPCODE_W-1:0],
                             flit_q[NBF_FLITS-2:0]});

endmodule

`default_nettype wire

// ==== nbf_issue.sv ====
/*
  Decodes loader packets and issues single-beat writes on the outbound port.
  Tracks outstanding writes against NBF_MAX_WRITES and holds fences until all are done.
*/
`timescale 1ns/1ps
`default_nettype none

module nbf_issue #(
  parameter int NBF_MAX_WRITES = 4
) (
  input  wire                                   clk,
  input  wire                                   reset,
  input  wire                                   pkt_valid_i,
  input  wire fpga_host_pkg::nbf_pkt_t          pkt_i,
  output logic                                  pkt_yumi_o,
  output logic                                  wr_valid_o,
  input  wire                                   wr_ready_i,
  output logic [fpga_host_pkg::NBF_ADDR_W-1:0]  wr_addr_o,
  output logic [fpga_host_pkg::NBF_DATA_W-1:0]  wr_data_o,
  output logic [1:0]                            wr_size_o,
  input  wire                                   wr_done_i
);

  import fpga_host_pkg::*;

  localparam int CRED_W = $clog2(NBF_MAX_WRITES + 1);

  logic [CRED_W-1:0] credits_q;
  logic              launch;
  logic              retire;
  logic              can_issue;
  logic              drained;
  logic              load_wr;
  logic              is_w32;

  assign launch = wr_valid_o & wr_ready_i;
  assign retire = wr_done_i & (credits_q != '0);

  // a new command needs an empty slot and a free credit
  assign can_issue = ~wr_valid_o & (credits_q < CRED_W'(NBF_MAX_WRITES));
  assign drained   = ~wr_valid_o & (credits_q == '0);
  assign is_w32    = (pkt_i.opcode == OP_WRITE32);

  always_comb begin
    load_wr    = 1'b0;
    pkt_yumi_o = 1'b0;
    case (pkt_i.opcode)
      OP_WRITE32, OP_WRITE64: begin
        load_wr    = pkt_valid_i & can_issue;
        pkt_yumi_o = load_wr;
      end
      OP_FENCE: begin
        pkt_yumi_o = pkt_valid_i & drained;
      end
      OP_FINISH: begin
        // nothing to do on the bridge side
        pkt_yumi_o = pkt_valid_i;
      end
      default: begin
        pkt_yumi_o = pkt_valid_i;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_valid_o <= 1'b0;
    end else if (load_wr) begin
      wr_valid_o <= 1'b1;
    end else if (launch) begin
      wr_valid_o <= 1'b0;
    end
  end

  // 32-bit writes put the low word in both halves
  always_ff @(posedge clk) begin
    if (load_wr) begin
      wr_addr_o <= pkt_i.addr;
      wr_data_o <= is_w32 ? {2{pkt_i.data[31:0]}} : pkt_i.data;
      wr_size_o <= is_w32 ? SIZE_32 : SIZE_64;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      credits_q <= '0;
    end else begin
      case ({launch, retire})
        2'b10:   credits_q <= credits_q + 1'b1;
        2'b01:   credits_q <= credits_q - 1'b1;
        default: credits_q <= credits_q;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# Builds the FPGA host bridge testbench with Verilator, runs it and checks the log.
# Exits nonzero when the build or the run fails, or when the pass line is missing.

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --top-module tb_fpga_host -f fpga_host.f \
    -o tb_fpga_host > build.log 2>&1; then
  cat build.log
  echo "verilator build failed"
  exit 1
fi

./obj_dir/tb_fpga_host > sim.log 2>&1
status=$?
cat sim.log

if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "all tests passed" sim.log; then
  exit 0
fi

echo "pass line not found in sim.log"
exit 1

// ==== tb_fpga_host.sv ====
/*
  Testbench for the FPGA host bridge: drives APB and the processor streams,
  predicts outbound writes with a reference model and checks them as they are accepted.
*/
`timescale 1ns/1ps
`default_nettype none

module tb_fpga_host;

  import fpga_host_pkg::*;

  localparam int MMIO_ELS       = 16;
  localparam int NBF_MAX_WRITES = 4;
  localparam int N_OUT_WORDS    = 5;
  // about 30 packets at 15 cycles each plus buffer traffic stay well below this limit
  localparam int TIMEOUT_CYCLES = 20000;

  logic                  clk;
  logic                  reset;
  logic                  psel_i;
  logic                  penable_i;
  logic                  pwrite_i;
  logic [CSR_ADDR_W-1:0] paddr_i;
  word_t                 pwdata_i;
  word_t                 prdata_o;
  logic                  pready_o;
  logic                  pslverr_o;
  logic                  wr_valid_o;
  logic                  wr_ready_i;
  logic [63:0]           wr_addr_o;
  logic [63:0]           wr_data_o;
  logic [1:0]            wr_size_o;
  logic                  wr_done_i;
  logic                  bp_in_valid_o;
  logic                  bp_in_ready_i;
  word_t                 bp_in_data_o;
  logic                  bp_out_valid_i;
  logic                  bp_out_ready_o;
  word_t                 bp_out_data_i;

  // expected writes pushed by the stimulus and read in order by the checker
  logic [63:0] exp_addr[$];
  logic [63:0] exp_data[$];
  logic [1:0]  exp_size[$];
  int          exp_min_ack[$];
  int          exp_rd       = 0;
  word_t       h2b_got[$];

  int    accepted_cnt = 0;
  int    acked_cnt    = 0;
  int    mon_errors   = 0;
  int    errors       = 0;
  int    tests_run    = 0;
  int    tests_failed = 0;
  int    test_err0    = 0;
  int    cycles       = 0;
  bit    ack_enable;
  string cur_test;

  fpga_host #(
    .MMIO_ELS       (MMIO_ELS),
    .NBF_MAX_WRITES (NBF_MAX_WRITES)
  ) u_dut (
    .clk            (clk),
    .reset          (reset),
    .psel_i         (psel_i),
    .penable_i      (penable_i),
    .pwrite_i       (pwrite_i),
    .paddr_i        (paddr_i),
    .pwdata_i       (pwdata_i),
    .prdata_o       (prdata_o),
    .pready_o       (pready_o),
    .pslverr_o      (pslverr_o),
    .wr_valid_o     (wr_valid_o),
    .wr_ready_i     (wr_ready_i),
    .wr_addr_o      (wr_addr_o),
    .wr_data_o      (wr_data_o),
    .wr_size_o      (wr_size_o),
    .wr_done_i      (wr_done_i),
    .bp_in_valid_o  (bp_in_valid_o),
    .bp_in_ready_i  (bp_in_ready_i),
    .bp_in_data_o   (bp_in_data_o),
    .bp_out_valid_i (bp_out_valid_i),
    .bp_out_ready_o (bp_out_ready_o),
    .bp_out_data_i  (bp_out_data_i)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles == TIMEOUT_CYCLES) begin
      $display("timeout: run stopped after %0d cycles in test %s", cycles, cur_test);
      $display("tests failed");
      $finish;
    end
  end

  // expected outbound write of a loader packet or 0 when none is issued
  function automatic bit ref_write(input nbf_pkt_t pkt, output logic [63:0] e_addr,
                                   output logic [63:0] e_data, output logic [1:0] e_size);
    e_addr = pkt.addr;
    e_data = pkt.data;
    e_size = SIZE_64;
    if (pkt.opcode == OP_WRITE64) begin
      return 1'b1;
    end
    if (pkt.opcode == OP_WRITE32) begin
      e_data = {2{pkt.data[31:0]}};
      e_size = SIZE_32;
      return 1'b1;
    end
    return 1'b0;
  endfunction

  function automatic logic [63:0] rand64();
    return {$urandom, $urandom};
  endfunction

  // write port responder with random back-pressure and one done pulse per accepted write
  always begin
    @(posedge clk);
    #2;
    wr_ready_i = ($urandom % 4) != 0;
    if (ack_enable && !reset && acked_cnt < accepted_cnt) begin
      wr_done_i = 1'b1;
      acked_cnt = acked_cnt + 1;
    end else begin
      wr_done_i = 1'b0;
    end
  end

  // checker sampled mid-cycle where all DUT outputs are settled
  always @(negedge clk) begin
    if (!reset && wr_valid_o && wr_ready_i) begin
      accepted_cnt = accepted_cnt + 1;
      if (exp_rd >= exp_addr.size()) begin
        mon_errors = mon_errors + 1;
        $display("unexpected write in test %s to address %h", cur_test, wr_addr_o);
      end else begin
        if (wr_addr_o !== exp_addr[exp_rd]) begin
          mon_errors = mon_errors + 1;
          $display("error %s: wr_addr expected %h actual %h",
                   cur_test, exp_addr[exp_rd], wr_addr_o);
        end
        if (wr_data_o !== exp_data[exp_rd]) begin
          mon_errors = mon_errors + 1;
          $display("error %s: wr_data expected %h actual %h",
                   cur_test, exp_data[exp_rd], wr_data_o);
        end
        if (wr_size_o !== exp_size[exp_rd]) begin
          mon_errors = mon_errors + 1;
          $display("error %s: wr_size expected %0d actual %0d",
                   cur_test, exp_size[exp_rd], wr_size_o);
        end
        if (acked_cnt < exp_min_ack[exp_rd]) begin
          mon_errors = mon_errors + 1;
          $display("write in test %s passed a fence with only %0d of %0d writes acknowledged",
                   cur_test, acked_cnt, exp_min_ack[exp_rd]);
        end
        exp_rd = exp_rd + 1;
      end
    end
    if (!reset && bp_in_valid_o && bp_in_ready_i) begin
      h2b_got.push_back(bp_in_data_o);
    end
  end

  task automatic apb_access(input logic wr, input logic [CSR_ADDR_W-1:0] addr,
                            input word_t wdata, output word_t rdata, output logic err);
    @(posedge clk);
    #2;
    psel_i    = 1'b1;
    penable_i = 1'b0;
    pwrite_i  = wr;
    paddr_i   = addr;
    pwdata_i  = wdata;
    @(posedge clk);
    #2;
    penable_i = 1'b1;
    @(negedge clk);
    while (!pready_o) @(negedge clk);
    rdata = prdata_o;
    err   = pslverr_o;
    @(posedge clk);
    #2;
    psel_i    = 1'b0;
    penable_i = 1'b0;
    pwrite_i  = 1'b0;
  endtask

  task automatic apb_write(input logic [CSR_ADDR_W-1:0] addr, input word_t data,
                           output logic err);
    word_t unused;
    apb_access(1'b1, addr, data, unused, err);
  endtask

  task automatic apb_read(input logic [CSR_ADDR_W-1:0] addr, output word_t data,
                          output logic err);
    apb_access(1'b0, addr, '0, data, err);
  endtask

  // five flits to 0x0 with random filler above the opcode
  task automatic send_packet(input logic [7:0] op, input logic [63:0] addr,
                             input logic [63:0] data, input int min_ack);
    nbf_pkt_t    pkt;
    logic [63:0] e_addr;
    logic [63:0] e_data;
    logic [1:0]  e_size;
    word_t       flits[NBF_FLITS];
    word_t       rnd;
    logic        err;
    int          i;
    pkt.opcode = op;
    pkt.addr   = addr;
    pkt.data   = data;
    if (ref_write(pkt, e_addr, e_data, e_size)) begin
      exp_addr.push_back(e_addr);
      exp_data.push_back(e_data);
      exp_size.push_back(e_size);
      exp_min_ack.push_back(min_ack);
    end
    rnd      = $urandom;
    flits[0] = data[31:0];
    flits[1] = data[63:32];
    flits[2] = addr[31:0];
    flits[3] = addr[63:32];
    flits[4] = {rnd[31:8], op};
    for (i = 0; i < NBF_FLITS; i++) begin
      apb_write(CSR_NBF, flits[i], err);
      if (err) begin
        errors++;
        $display("loader flit %0d in test %s completed with pslverr", i, cur_test);
      end
    end
  endtask

  task automatic drain_writes();
    while (exp_rd < exp_addr.size() || acked_cnt < accepted_cnt) @(posedge clk);
  endtask

  task automatic wait_accepted(input int target, input int limit, output bit ok);
    int n;
    n = 0;
    while (accepted_cnt < target && n < limit) begin
      @(posedge clk);
      n++;
    end
    ok = (accepted_cnt >= target);
  endtask

  task automatic push_bp_out(input word_t w);
    @(posedge clk);
    #2;
    bp_out_valid_i = 1'b1;
    bp_out_data_i  = w;
    @(negedge clk);
    while (!bp_out_ready_o) @(negedge clk);
    @(posedge clk);
    #2;
    bp_out_valid_i = 1'b0;
  endtask

  task automatic start_test(input string name);
    cur_test  = name;
    test_err0 = errors + mon_errors;
  endtask

  task automatic end_test();
    int n;
    n = errors + mon_errors - test_err0;
    tests_run++;
    if (n == 0) begin
      $display("test %s: ok", cur_test);
    end else begin
      tests_failed++;
      $display("test %s: %0d errors", cur_test, n);
    end
  endtask

  task automatic credit_fence_test();
    int base_acc;
    int base_ack;
    int i;
    bit ok;
    start_test("credits and fence");
    ack_enable = 1'b0;
    base_acc   = accepted_cnt;
    for (i = 0; i < NBF_MAX_WRITES + 2; i++) begin
      send_packet(OP_WRITE64, rand64(), rand64(), 0);
    end
    wait_accepted(base_acc + NBF_MAX_WRITES, 200, ok);
    if (!ok) begin
      errors++;
      $display("writes stopped before the credit limit in test %s", cur_test);
    end
    repeat (40) @(posedge clk);
    if (accepted_cnt != base_acc + NBF_MAX_WRITES) begin
      errors++;
      $display("error %s: accepted writes expected %0d actual %0d",
               cur_test, NBF_MAX_WRITES, accepted_cnt - base_acc);
    end
    ack_enable = 1'b1;
    drain_writes();
    // two writes in flight followed by the fence and one write behind it
    base_acc   = accepted_cnt;
    base_ack   = acked_cnt;
    ack_enable = 1'b0;
    send_packet(OP_WRITE64, rand64(), rand64(), 0);
    send_packet(OP_WRITE32, rand64(), rand64(), 0);
    send_packet(OP_FENCE, rand64(), rand64(), 0);
    send_packet(OP_WRITE64, rand64(), rand64(), base_ack + 2);
    wait_accepted(base_acc + 2, 200, ok);
    repeat (40) @(posedge clk);
    if (accepted_cnt != base_acc + 2) begin
      errors++;
      $display("error %s: writes before fence release expected %0d actual %0d",
               cur_test, 2, accepted_cnt - base_acc);
    end
    ack_enable = 1'b1;
    drain_writes();
    end_test();
  endtask

  task automatic host_to_bp_test();
    word_t sent[$];
    word_t w;
    logic  err;
    bit    done_last;
    int    base;
    int    i;
    int    n;
    start_test("host to processor");
    base = h2b_got.size();
    for (i = 0; i < MMIO_ELS; i++) begin
      w = $urandom;
      sent.push_back(w);
      apb_write(CSR_HOST_TO_BP, w, err);
      if (err) begin
        errors++;
        $display("write %0d to 0x4 in test %s completed with pslverr", i, cur_test);
      end
    end
    w = $urandom;
    sent.push_back(w);
    done_last = 1'b0;
    fork
      begin
        apb_write(CSR_HOST_TO_BP, w, err);
        done_last = 1'b1;
      end
      begin
        repeat (10) @(posedge clk);
        if (done_last) begin
          errors++;
          $display("write to a full buffer completed in test %s", cur_test);
        end
        #2;
        bp_in_ready_i = 1'b1;
        @(posedge clk);
        #2;
        bp_in_ready_i = 1'b0;
        n = 0;
        while (!done_last && n < 10) begin
          @(posedge clk);
          n++;
        end
        if (!done_last) begin
          errors++;
          $display("write stayed stalled after a word drained in test %s", cur_test);
        end
      end
    join
    @(posedge clk);
    #2;
    bp_in_ready_i = 1'b1;
    while (h2b_got.size() < base + MMIO_ELS + 1) @(posedge clk);
    for (i = 0; i <= MMIO_ELS; i++) begin
      if (h2b_got[base + i] !== sent[i]) begin
        errors++;
        $display("error %s: bp_in word %0d expected %h actual %h",
                 cur_test, i, sent[i], h2b_got[base + i]);
      end
    end
    end_test();
  endtask

  task automatic bp_to_host_test();
    word_t sent[$];
    word_t rd;
    logic  err;
    int    i;
    start_test("processor to host");
    for (i = 0; i < N_OUT_WORDS; i++) begin
      sent.push_back($urandom);
      push_bp_out(sent[i]);
    end
    apb_read(CSR_BP_TO_HOST_CNT, rd, err);
    if (rd !== word_t'(N_OUT_WORDS) || err) begin
      errors++;
      $display("error %s: count expected %0d actual %0d (pslverr %b)",
               cur_test, N_OUT_WORDS, rd, err);
    end
    for (i = 0; i < N_OUT_WORDS; i++) begin
      apb_read(CSR_BP_TO_HOST, rd, err);
      if (rd !== sent[i] || err) begin
        errors++;
        $display("error %s: pop %0d expected %h actual %h", cur_test, i, sent[i], rd);
      end
    end
    apb_read(CSR_BP_TO_HOST, rd, err);
    if (rd !== '0 || err) begin
      errors++;
      $display("error %s: empty pop expected %h actual %h", cur_test, 32'h0, rd);
    end
    apb_read(4'h2, rd, err);
    if (!err || rd !== '0) begin
      errors++;
      $display("read of unmapped 0x2 in test %s gave no slave error", cur_test);
    end
    apb_write(CSR_BP_TO_HOST_CNT, $urandom, err);
    if (!err) begin
      errors++;
      $display("write to read-only 0x8 in test %s gave no slave error", cur_test);
    end
    apb_read(CSR_BP_TO_HOST_CNT, rd, err);
    if (rd !== '0 || err) begin
      errors++;
      $display("error %s: final count expected %0d actual %0d", cur_test, 0, rd);
    end
    end_test();
  endtask

  initial begin
    int i;
    void'($urandom(46));
    reset          = 1'b1;
    psel_i         = 1'b0;
    penable_i      = 1'b0;
    pwrite_i       = 1'b0;
    paddr_i        = '0;
    pwdata_i       = '0;
    wr_ready_i     = 1'b0;
    wr_done_i      = 1'b0;
    bp_in_ready_i  = 1'b0;
    bp_out_valid_i = 1'b0;
    bp_out_data_i  = '0;
    ack_enable     = 1'b1;
    cur_test       = "reset";
    repeat (2) @(posedge clk);
    #2;
    reset = 1'b0;

    start_test("reset state");
    if (wr_valid_o !== 1'b0 || bp_in_valid_o !== 1'b0 || pslverr_o !== 1'b0) begin
      errors++;
      $display("outputs not idle after reset");
    end
    end_test();

    start_test("64-bit writes");
    for (i = 0; i < 10; i++) begin
      send_packet(OP_WRITE64, rand64(), rand64(), 0);
    end
    drain_writes();
    end_test();

    start_test("32-bit writes");
    for (i = 0; i < 6; i++) begin
      send_packet(OP_WRITE32, rand64(), rand64(), 0);
    end
    drain_writes();
    end_test();

    credit_fence_test();

    // finish and unknown opcodes vanish but the write behind them still goes out
    start_test("consumed opcodes");
    send_packet(OP_FINISH, rand64(), rand64(), 0);
    send_packet(8'h00, rand64(), rand64(), 0);
    send_packet(8'h7A, rand64(), rand64(), 0);
    send_packet(OP_WRITE64, rand64(), rand64(), 0);
    drain_writes();
    end_test();

    host_to_bp_test();
    bp_to_host_test();

    $display("summary: %0d run, %0d failing, %0d check errors",
             tests_run, tests_failed, errors + mon_errors);
    if (tests_failed == 0 && errors + mon_errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== word_fifo.sv ====
/*
  Synchronous FIFO with a type-parameter payload and an occupancy count.
  Push is valid/ready, pop is valid/yumi; a push shows at the output one cycle later.
*/
`timescale 1ns/1ps
`default_nettype none

module word_fifo #(
  parameter int  MMIO_ELS  = 16,
  parameter type payload_t = logic [31:0]
) (
  input  wire                              clk,
  input  wire                              reset,
  input  wire                              push_valid_i,
  input  wire payload_t                    push_data_i,
  output logic                             push_ready_o,
  output logic                             pop_valid_o,
  output payload_t                         pop_data_o,
  input  wire                              pop_yumi_i,
  output logic [$clog2(MMIO_ELS+1)-1:0]    count_o
);

  localparam int PTR_W = (MMIO_ELS > 1) ? $clog2(MMIO_ELS) : 1;
  localparam int CNT_W = $clog2(MMIO_ELS + 1);

  payload_t         mem [MMIO_ELS];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             push_fire;
  logic             pop_fire;

  // wrap explicitly so any depth works
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(MMIO_ELS - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign push_ready_o = (count_q != CNT_W'(MMIO_ELS));
  assign pop_valid_o  = (count_q != '0);
  assign pop_data_o   = mem[rd_ptr_q];
  assign count_o      = count_q;

  // full push and empty pop are refused here
  assign push_fire = push_valid_i & push_ready_o;
  assign pop_fire  = pop_yumi_i & pop_valid_o;

  always_ff @(posedge clk) begin
    if (push_fire) begin
      mem[wr_ptr_q] <= push_data_i;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_fire) begin
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      end
      if (pop_fire) begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      end
      case ({push_fire, pop_fire})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

endmodule

`default_nettype wire
